// ==== act_fetch.sv ====
`timescale 1ns/1ps

module act_fetch (
    input  logic clk,
    input  logic rst_n,
    input  logic rd_valid,
    input  conv_pkg::pos_t rd_bx,
    input  conv_pkg::pos_t rd_by,
    input  conv_pkg::act_word_u sram_rdata_0,
    input  conv_pkg::act_word_u sram_rdata_1,
    input  conv_pkg::act_word_u sram_rdata_2,
    input  conv_pkg::act_word_u sram_rdata_3,
    act_if.src act
);
    logic tag_valid;
    conv_pkg::pos_t tag_bx;
    conv_pkg::pos_t tag_by;
    conv_pkg::act_word_u word;

    // tag lines up with the synchronous read data
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tag_valid <= 1'b0;
            act.valid <= 1'b0;
        end else begin
            tag_valid <= rd_valid;
            act.valid <= tag_valid;
        end
    end

    always_ff @(posedge clk) begin
        tag_bx <= rd_bx;
        tag_by <= rd_by;
        act.bx <= tag_bx;
        act.by <= tag_by;
        act.act <= word;
    end

    // bank from y and x parity
    always_comb begin
        case ({tag_by[0], tag_bx[0]})
            2'b00: word = sram_rdata_0;
            2'b01: word = sram_rdata_1;
            2'b10: word = sram_rdata_2;
            default: word = sram_rdata_3;
        endcase
    end

endmodule

// ==== conv_cfg.svh ====
`ifndef CONV_CFG_SVH
`define CONV_CFG_SVH

// blocks per row and per column
`define CONV_GRID_X 20
`define CONV_GRID_Y 16

// channels, and pixels per channel in one bank word
`define CONV_CH 3
`define CONV_PIX 9

// activation, weight and bias width
`define CONV_ELEM_W 10
`define CONV_ACC_W 23

// bias sits 8 bits up and the result is taken from bit 8
`define CONV_BIAS_SHIFT 8
`define CONV_ROUND 128

`define CONV_ADDR_W 9
`define CONV_WADDR_W 7

`endif

// ==== conv_ctrl.sv ====
`timescale 1ns/1ps
`include "conv_cfg.svh"

module conv_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic enable,
    input  logic last_written,
    input  logic shift_finish,
    output logic rd_valid,
    output conv_pkg::pos_t rd_bx,
    output conv_pkg::pos_t rd_by,
    output logic [`CONV_ADDR_W-1:0] sram_raddr,
    output logic [4:0] sram_raddr_bias,
    output logic bias_load,
    output logic [1:0] bias_sel,
    output logic valid_conv1,
    output logic valid
);
    localparam int addr_w = `CONV_ADDR_W;

    conv_pkg::layer_state_e state;
    conv_pkg::pos_t bx;
    conv_pkg::pos_t by;
    logic [1:0] bias_cnt;
    logic issue_done;
    logic issue;
    logic last_issue;

    assign issue = (state == conv_pkg::st_stream) && !issue_done;
    assign last_issue = issue && bx == conv_pkg::pos_t'(`CONV_GRID_X - 1)
                        && by == conv_pkg::pos_t'(`CONV_GRID_Y - 1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= conv_pkg::st_idle;
            bx <= '0;
            by <= '0;
            bias_cnt <= '0;
            issue_done <= 1'b0;
            rd_valid <= 1'b0;
            bias_load <= 1'b0;
            bias_sel <= '0;
        end else begin
            rd_valid <= issue;
            // bias data comes back one cycle after its address
            bias_load <= (state == conv_pkg::st_bias_load);
            bias_sel <= bias_cnt;
            case (state)
                conv_pkg::st_idle: begin
                    if (enable) begin
                        state <= conv_pkg::st_bias_load;
                        bias_cnt <= '0;
                        bx <= '0;
                        by <= '0;
                        issue_done <= 1'b0;
                    end
                end
                conv_pkg::st_bias_load: begin
                    bias_cnt <= bias_cnt + 2'd1;
                    if (bias_cnt == 2'd2) begin
                        state <= conv_pkg::st_stream;
                    end
                end
                conv_pkg::st_stream: begin
                    if (last_issue) begin
                        issue_done <= 1'b1;
                    end else if (issue) begin
                        if (bx == conv_pkg::pos_t'(`CONV_GRID_X - 1)) begin
                            bx <= '0;
                            by <= by + 7'd1;
                        end else begin
                            bx <= bx + 7'd1;
                        end
                    end
                    // pipeline drained once the last block lands
                    if (last_written) begin
                        state <= conv_pkg::st_wait_shift;
                    end
                end
                conv_pkg::st_wait_shift: begin
                    if (shift_finish) begin
                        state <= conv_pkg::st_finish;
                    end
                end
                default: state <= conv_pkg::st_finish;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        rd_bx <= bx;
        rd_by <= by;
        sram_raddr <= addr_w'(bx[6:1]) + addr_w'(by[6:1]) * addr_w'(10);
        if (state == conv_pkg::st_bias_load && bias_cnt != 2'd2) begin
            sram_raddr_bias <= {3'b000, bias_cnt} + 5'd1;
        end else begin
            sram_raddr_bias <= '0;
        end
    end

    assign valid_conv1 = (state == conv_pkg::st_wait_shift);
    assign valid = (state == conv_pkg::st_finish);

endmodule

// ==== conv_if.sv ====
`timescale 1ns/1ps

// fetched bank word with its block position
interface act_if;
    logic valid;
    conv_pkg::pos_t bx;
    conv_pkg::pos_t by;
    conv_pkg::act_word_u act;

    modport src (
        output valid,
        output bx,
        output by,
        output act
    );
    modport dst (
        input valid,
        input bx,
        input by,
        input act
    );
endinterface

// biased accumulator sums with their block position
interface sum_if;
    logic valid;
    conv_pkg::pos_t bx;
    conv_pkg::pos_t by;
    conv_pkg::sum_word_t sum;

    modport src (
        output valid,
        output bx,
        output by,
        output sum
    );
    modport dst (
        input valid,
        input bx,
        input by,
        input sum
    );
endinterface

// ==== conv_pkg.sv ====
`include "conv_cfg.svh"

package conv_pkg;

    typedef logic signed [`CONV_ELEM_W-1:0] elem_t;
    typedef logic signed [`CONV_ACC_W-1:0] acc_t;
    typedef logic [6:0] pos_t;

    // one bank word as 27 elements or as channel by pixel
    typedef union packed {
        elem_t [`CONV_CH*`CONV_PIX-1:0] flat;
        elem_t [`CONV_CH-1:0][`CONV_PIX-1:0] ch;
    } act_word_u;

    typedef acc_t [`CONV_CH*`CONV_PIX-1:0] sum_word_t;

    typedef enum logic [2:0] {
        st_idle,
        st_bias_load,
        st_stream,
        st_wait_shift,
        st_finish
    } layer_state_e;

endpackage

// ==== conv_sva.sv ====
`timescale 1ns/1ps

module conv_sva (
    input logic clk,
    input logic rst_n,
    input logic sram_wen_0,
    input logic sram_wen_1,
    input logic sram_wen_2,
    input logic sram_wen_3,
    input logic valid_conv1,
    input logic valid
);
    logic [3:0] wen_low;

    assign wen_low = ~{sram_wen_3, sram_wen_2, sram_wen_1, sram_wen_0};

    // one bank written per cycle at most
    one_bank_write: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(wen_low))
        else $error("more than one bank write enable low: %b", wen_low);

    status_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(valid && valid_conv1))
        else $error("valid and valid_conv1 high in the same cycle");

    no_write_after_finish: assert property (@(posedge clk) disable iff (!rst_n)
        valid |-> wen_low == 4'b0000)
        else $error("bank write while valid is high");
endmodule

bind conv_top conv_sva i_conv_sva (
    .clk(clk),
    .rst_n(rst_n),
    .sram_wen_0(sram_wen_0),
    .sram_wen_1(sram_wen_1),
    .sram_wen_2(sram_wen_2),
    .sram_wen_3(sram_wen_3),
    .valid_conv1(valid_conv1),
    .valid(valid)
);

// ==== conv_top.f ====
+incdir+.
conv_pkg.sv
conv_if.sv
conv_ctrl.sv
act_fetch.sv
pointwise_mac.sv
result_writer.sv
conv_top.sv
conv_sva.sv
tb_conv_top.sv

// ==== conv_top.sv ====
`timescale 1ns/1ps
`include "conv_cfg.svh"

module conv_top (
    input  logic clk,
    input  logic rst_n,
    input  logic enable,
    input  conv_pkg::act_word_u sram_rdata_0,
    input  conv_pkg::act_word_u sram_rdata_1,
    input  conv_pkg::act_word_u sram_rdata_2,
    input  conv_pkg::act_word_u sram_rdata_3,
    input  conv_pkg::elem_t [`CONV_PIX-1:0] sram_rdata_weight,
    input  conv_pkg::elem_t sram_rdata_bias,
    output logic [`CONV_ADDR_W-1:0] sram_raddr,
    output logic [4:0] sram_raddr_bias,
    output logic sram_wen_0,
    output logic sram_wen_1,
    output logic sram_wen_2,
    output logic sram_wen_3,
    output logic [`CONV_WADDR_W-1:0] sram_waddr,
    output conv_pkg::act_word_u sram_wdata,
    output logic valid_conv1,
    input  logic shift_finish,
    output logic valid
);
    logic rd_valid;
    conv_pkg::pos_t rd_bx;
    conv_pkg::pos_t rd_by;
    logic bias_load;
    logic [1:0] bias_sel;
    logic last_written;

    act_if act_bus ();
    sum_if sum_bus ();

    conv_ctrl i_conv_ctrl (
        .clk(clk),
        .rst_n(rst_n),
        .enable(enable),
        .last_written(last_written),
        .shift_finish(shift_finish),
        .rd_valid(rd_valid),
        .rd_bx(rd_bx),
        .rd_by(rd_by),
        .sram_raddr(sram_raddr),
        .sram_raddr_bias(sram_raddr_bias),
        .bias_load(bias_load),
        .bias_sel(bias_sel),
        .valid_conv1(valid_conv1),
        .valid(valid)
    );

    act_fetch i_act_fetch (
        .clk(clk),
        .rst_n(rst_n),
        .rd_valid(rd_valid),
        .rd_bx(rd_bx),
        .rd_by(rd_by),
        .sram_rdata_0(sram_rdata_0),
        .sram_rdata_1(sram_rdata_1),
        .sram_rdata_2(sram_rdata_2),
        .sram_rdata_3(sram_rdata_3),
        .act(act_bus.src)
    );

    pointwise_mac i_pointwise_mac (
        .clk(clk),
        .rst_n(rst_n),
        .sram_rdata_weight(sram_rdata_weight),
        .sram_rdata_bias(sram_rdata_bias),
        .bias_load(bias_load),
        .bias_sel(bias_sel),
        .act(act_bus.dst),
        .sum(sum_bus.src)
    );

    result_writer i_result_writer (
        .clk(clk),
        .rst_n(rst_n),
        .sum(sum_bus.dst),
        .sram_wen_0(sram_wen_0),
        .sram_wen_1(sram_wen_1),
        .sram_wen_2(sram_wen_2),
        .sram_wen_3(sram_wen_3),
        .sram_waddr(sram_waddr),
        .sram_wdata(sram_wdata),
        .last_written(last_written)
    );

endmodule

// ==== pointwise_mac.sv ====
`timescale 1ns/1ps
`include "conv_cfg.svh"

module pointwise_mac (
    input  logic clk,
    input  logic rst_n,
    input  conv_pkg::elem_t [`CONV_PIX-1:0] sram_rdata_weight,
    input  conv_pkg::elem_t sram_rdata_bias,
    input  logic bias_load,
    input  logic [1:0] bias_sel,
    act_if.dst act,
    sum_if.src sum
);
    conv_pkg::elem_t [`CONV_PIX-1:0] w;
    conv_pkg::acc_t bias [`CONV_CH];
    // indexed by output channel, input channel, pixel
    conv_pkg::acc_t prod [`CONV_CH][`CONV_CH][`CONV_PIX];
    logic prod_valid;
    conv_pkg::pos_t prod_bx;
    conv_pkg::pos_t prod_by;

    // weights and biases are loaded before streaming starts
    always_ff @(posedge clk) begin
        if (bias_load) begin
            w <= sram_rdata_weight;
            bias[bias_sel] <= conv_pkg::acc_t'(sram_rdata_bias) <<< `CONV_BIAS_SHIFT;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prod_valid <= 1'b0;
            sum.valid <= 1'b0;
        end else begin
            prod_valid <= act.valid;
            sum.valid <= prod_valid;
        end
    end

    // first stage forms the channel mixing products
    always_ff @(posedge clk) begin
        prod_bx <= act.bx;
        prod_by <= act.by;
        for (int s = 0; s < `CONV_CH; s++) begin
            for (int n = 0; n < `CONV_CH; n++) begin
                for (int k = 0; k < `CONV_PIX; k++) begin
                    prod[s][n][k] <= $signed(act.act.ch[n][k]) * $signed(w[3*s+n]);
                end
            end
        end
    end

    // second stage adds the bias and three products
    always_ff @(posedge clk) begin
        sum.bx <= prod_bx;
        sum.by <= prod_by;
        for (int s = 0; s < `CONV_CH; s++) begin
            for (int k = 0; k < `CONV_PIX; k++) begin
                sum.sum[`CONV_PIX*s+k] <= bias[s] + prod[s][0][k] + prod[s][1][k]
                                          + prod[s][2][k];
            end
        end
    end

endmodule

// ==== result_writer.sv ====
`timescale 1ns/1ps
`include "conv_cfg.svh"

module result_writer (
    input  logic clk,
    input  logic rst_n,
    sum_if.dst sum,
    output logic sram_wen_0,
    output logic sram_wen_1,
    output logic sram_wen_2,
    output logic sram_wen_3,
    output logic [`CONV_WADDR_W-1:0] sram_waddr,
    output conv_pkg::act_word_u sram_wdata,
    output logic last_written
);
    localparam int waddr_w = `CONV_WADDR_W;

    conv_pkg::acc_t rounded [`CONV_CH*`CONV_PIX];
    conv_pkg::act_word_u word_n;
    logic [1:0] bank;

    assign bank = {sum.by[0], sum.bx[0]};

    // round half up, then keep the 10 bits above the fraction
    always_comb begin
        for (int r = 0; r < `CONV_CH*`CONV_PIX; r++) begin
            rounded[r] = sum.sum[r] + conv_pkg::acc_t'(`CONV_ROUND);
            word_n.flat[r] = rounded[r][`CONV_BIAS_SHIFT +: `CONV_ELEM_W];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sram_wen_0 <= 1'b1;
            sram_wen_1 <= 1'b1;
            sram_wen_2 <= 1'b1;
            sram_wen_3 <= 1'b1;
            last_written <= 1'b0;
        end else begin
            sram_wen_0 <= !(sum.valid && bank == 2'd0);
            sram_wen_1 <= !(sum.valid && bank == 2'd1);
            sram_wen_2 <= !(sum.valid && bank == 2'd2);
            sram_wen_3 <= !(sum.valid && bank == 2'd3);
            last_written <= sum.valid
                            && sum.bx == conv_pkg::pos_t'(`CONV_GRID_X - 1)
                            && sum.by == conv_pkg::pos_t'(`CONV_GRID_Y - 1);
        end
    end

    // same address the block was read from
    always_ff @(posedge clk) begin
        sram_waddr <= waddr_w'(sum.bx[6:1]) + waddr_w'(sum.by[6:1]) * waddr_w'(10);
        sram_wdata <= word_n;
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the conv_top testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_conv_top -f conv_top.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_conv_top > sim.log 2>&1
status=$?
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0

// ==== tb_conv_top.sv ====
`timescale 1ns/1ps
`include "conv_cfg.svh"

module tb_conv_top;
    localparam int n_rows = 4;
    localparam int n_blocks = `CONV_GRID_X * `CONV_GRID_Y;
    localparam int bank_words = n_blocks / 4;
    localparam int half_x = `CONV_GRID_X / 2;
    localparam int elem_max = (1 << (`CONV_ELEM_W - 1)) - 1;
    localparam int elem_min = -(1 << (`CONV_ELEM_W - 1));
    localparam int fill_lfsr = 0;
    localparam int fill_max = 1;
    localparam int fill_min = 2;

    // one row per run with fill, weights, biases, shift_finish delay and uniform result
    localparam int fill_tbl [n_rows] = '{fill_lfsr, fill_lfsr, fill_max, fill_min};
    localparam int weight_tbl [n_rows][`CONV_PIX] = '{
        '{37, -5, 120, -200, 511, -512, 3, 0, -77},
        '{-1, 1, 255, -256, 64, -64, 500, -499, 13},
        '{511, 511, 511, 511, 511, 511, 511, 511, 511},
        '{-512, -512, -512, -512, -512, -512, -512, -512, -512}
    };
    localparam int bias_tbl [n_rows][`CONV_CH] = '{
        '{100, -300, 7}, '{-512, 511, 0}, '{511, 511, 511}, '{-512, -512, -512}
    };
    localparam int delay_tbl [n_rows] = '{3, 0, 7, 1};
    // every element of a uniform fill wraps to this value
    localparam int expect_tbl [n_rows] = '{0, 0, 499, -512};

    logic clk = 1'b0;
    logic rst_n;
    logic enable;
    logic shift_finish;
    logic load_banks;
    conv_pkg::act_word_u rdata [4] = '{default: '0};
    conv_pkg::act_word_u sram_wdata;
    conv_pkg::elem_t [`CONV_PIX-1:0] sram_rdata_weight;
    conv_pkg::elem_t sram_rdata_bias = '0;
    logic [`CONV_ADDR_W-1:0] sram_raddr;
    logic [4:0] sram_raddr_bias;
    logic sram_wen_0;
    logic sram_wen_1;
    logic sram_wen_2;
    logic sram_wen_3;
    logic [3:0] wen;
    logic [`CONV_WADDR_W-1:0] sram_waddr;
    logic valid_conv1;
    logic valid;

    conv_pkg::act_word_u bank_mem [4][bank_words];
    conv_pkg::act_word_u orig_mem [4][bank_words];
    conv_pkg::elem_t bias_mem [`CONV_CH];
    int write_cnt [`CONV_GRID_Y][`CONV_GRID_X];
    int write_total;
    logic bad_waddr;
    logic [31:0] lfsr;
    int error_count;

    always #20 clk = ~clk;

    assign wen = {sram_wen_3, sram_wen_2, sram_wen_1, sram_wen_0};

    conv_top i_conv_top (
        .clk(clk),
        .rst_n(rst_n),
        .enable(enable),
        .sram_rdata_0(rdata[0]),
        .sram_rdata_1(rdata[1]),
        .sram_rdata_2(rdata[2]),
        .sram_rdata_3(rdata[3]),
        .sram_rdata_weight(sram_rdata_weight),
        .sram_rdata_bias(sram_rdata_bias),
        .sram_raddr(sram_raddr),
        .sram_raddr_bias(sram_raddr_bias),
        .sram_wen_0(sram_wen_0),
        .sram_wen_1(sram_wen_1),
        .sram_wen_2(sram_wen_2),
        .sram_wen_3(sram_wen_3),
        .sram_waddr(sram_waddr),
        .sram_wdata(sram_wdata),
        .valid_conv1(valid_conv1),
        .shift_finish(shift_finish),
        .valid(valid)
    );

    // bank and bias SRAMs with read data one cycle after the address
    always @(posedge clk) begin
        int wx;
        int wy;
        if (load_banks) begin
            bank_mem <= orig_mem;
            write_cnt <= '{default: 0};
            write_total <= 0;
            bad_waddr <= 1'b0;
        end else begin
            for (int b = 0; b < 4; b++) begin
                wx = 2 * (int'(sram_waddr) % half_x) + b % 2;
                wy = 2 * (int'(sram_waddr) / half_x) + b / 2;
                if (wen[b] == 1'b0 && wy < `CONV_GRID_Y) begin
                    bank_mem[b][sram_waddr] <= sram_wdata;
                    write_cnt[wy][wx] <= write_cnt[wy][wx] + 1;
                    write_total <= write_total + 1;
                end else if (wen[b] == 1'b0) begin
                    bad_waddr <= 1'b1;
                end
            end
        end
        for (int b = 0; b < 4; b++) begin
            rdata[b] <= (sram_raddr < bank_words) ? bank_mem[b][sram_raddr] : '0;
        end
        sram_rdata_bias <= (sram_raddr_bias < `CONV_CH) ? bias_mem[sram_raddr_bias] : '0;
    end

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_elem(output conv_pkg::elem_t v);
        for (int i = 0; i < `CONV_ELEM_W; i++) begin
            lfsr = lfsr_next(lfsr);
            v[i] = lfsr[0];
        end
    endtask

    function automatic int expected_elem(input conv_pkg::act_word_u src, input int row,
                                         input int s, input int k);
        int acc;
        acc = bias_tbl[row][s] * (1 << `CONV_BIAS_SHIFT) + `CONV_ROUND;
        for (int n = 0; n < `CONV_CH; n++) begin
            acc += int'(src.ch[n][k]) * weight_tbl[row][3 * s + n];
        end
        // drop the fraction and keep the low 10 bits as signed
        return int'(conv_pkg::elem_t'(acc >>> `CONV_BIAS_SHIFT));
    endfunction

    task automatic stop_with_failure();
        error_count++;
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input int got, input int want);
        $display("Fail at %0t ns: %s = %0d, expected %0d", $time, name, got, want);
        stop_with_failure();
    endtask

    task automatic check_status(input logic want_valid, input logic want_conv1);
        assert (valid == want_valid) else report_mismatch("valid", valid, want_valid);
        assert (valid_conv1 == want_conv1)
            else report_mismatch("valid_conv1", valid_conv1, want_conv1);
    endtask

    task automatic fill_banks(input int row);
        conv_pkg::elem_t e;
        for (int b = 0; b < 4; b++) begin
            for (int a = 0; a < bank_words; a++) begin
                for (int i = 0; i < `CONV_CH * `CONV_PIX; i++) begin
                    case (fill_tbl[row])
                        fill_max: e = conv_pkg::elem_t'(elem_max);
                        fill_min: e = conv_pkg::elem_t'(elem_min);
                        default: random_elem(e);
                    endcase
                    orig_mem[b][a].flat[i] = e;
                end
            end
        end
        for (int s = 0; s < `CONV_CH; s++) begin
            bias_mem[s] = conv_pkg::elem_t'(bias_tbl[row][s]);
        end
        for (int i = 0; i < `CONV_PIX; i++) begin
            sram_rdata_weight[i] = conv_pkg::elem_t'(weight_tbl[row][i]);
        end
        load_banks = 1'b1;
        @(negedge clk);
        load_banks = 1'b0;
    endtask

    task automatic wait_layer_done();
        int cycles;
        cycles = 0;
        while (!valid_conv1 && cycles < 1000) begin
            @(negedge clk);
            cycles++;
            assert (!valid) else report_mismatch("valid", valid, 0);
        end
        assert (valid_conv1) else begin
            $display("Timeout: valid_conv1 did not rise within %0d cycles", cycles);
            stop_with_failure();
        end
        assert (write_total == n_blocks)
            else report_mismatch("write count total", write_total, n_blocks);
        assert (!bad_waddr) else begin
            $display("A write used an sram_waddr outside the bank");
            stop_with_failure();
        end
    endtask

    task automatic wait_run_done();
        int cycles;
        cycles = 0;
        while (!valid && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        assert (valid) else begin
            $display("Timeout: valid did not rise within %0d cycles of shift_finish", cycles);
            stop_with_failure();
        end
        check_status(1'b1, 1'b0);
    endtask

    task automatic check_results(input int row);
        int b;
        int a;
        int got;
        int want;
        for (int y = 0; y < `CONV_GRID_Y; y++) begin
            for (int x = 0; x < `CONV_GRID_X; x++) begin
                b = 2 * (y % 2) + x % 2;
                a = x / 2 + half_x * (y / 2);
                assert (write_cnt[y][x] == 1) else report_mismatch(
                    $sformatf("write count of block (%0d,%0d)", x, y), write_cnt[y][x], 1);
                for (int s = 0; s < `CONV_CH; s++) begin
                    for (int k = 0; k < `CONV_PIX; k++) begin
                        want = expected_elem(orig_mem[b][a], row, s, k);
                        got = int'(bank_mem[b][a].flat[`CONV_PIX * s + k]);
                        assert (got == want) else report_mismatch($sformatf(
                            "sram_wdata bank %0d addr %0d elem %0d", b, a, 9 * s + k), got, want);
                        if (fill_tbl[row] != fill_lfsr) begin
                            assert (got == expect_tbl[row]) else report_mismatch(
                                "sram_wdata uniform element", got, expect_tbl[row]);
                        end
                    end
                end
            end
        end
    endtask

    task automatic run_row(input int row);
        int held;
        rst_n = 1'b0;
        enable = 1'b0;
        shift_finish = 1'b0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        fill_banks(row);
        repeat (3) begin
            check_status(1'b0, 1'b0);
            assert (wen == 4'hf) else report_mismatch("sram_wen_3..0", wen, 15);
            @(negedge clk);
        end
        enable = 1'b1;
        @(negedge clk);
        enable = 1'b0;
        wait_layer_done();
        for (int i = 0; i < delay_tbl[row]; i++) begin
            @(negedge clk);
            check_status(1'b0, 1'b1);
        end
        shift_finish = 1'b1;
        @(negedge clk);
        shift_finish = 1'b0;
        wait_run_done();
        // a late enable must leave the finished layer alone
        held = write_total;
        enable = 1'b1;
        @(negedge clk);
        enable = 1'b0;
        repeat (10) begin
            @(negedge clk);
            check_status(1'b1, 1'b0);
            assert (write_total == held)
                else report_mismatch("write count after finish", write_total, held);
        end
        check_results(row);
    endtask

    initial begin
        rst_n = 1'b0;
        enable = 1'b0;
        shift_finish = 1'b0;
        load_banks = 1'b0;
        sram_rdata_weight = '0;
        lfsr = 32'h8281_be04;
        error_count = 0;
        for (int r = 0; r < n_rows; r++) begin
            run_row(r);
        end
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
